// ==== src.f ====
+incdir+dv
verilog/mix_pkg.sv
verilog/mix_param_regs.sv
verilog/mix_slot_decode.sv
verilog/mix_voice_execute.sv
verilog/mix_stereo_result.sv
verilog/voice_mixer.sv
dv/voice_mixer_tb.sv

// ==== dv/mix_model.svh ====
`ifndef MIX_MODEL_SVH
`define MIX_MODEL_SVH

// sample times envelope
function automatic longint amp_of(input longint sine, input longint env);
    return (sine * env) >>> 7;
endfunction

// one 7-bit gain step with an arithmetic shift
function automatic longint gain(input longint x, input longint g);
    return (x * g) >>> 7;
endfunction

function automatic logic [10:0] slot_mod(input longint amp, input longint amt);
    longint v;
    v = (amp * amt) >>> 14;
    return v[10:0];
endfunction

function automatic logic [23:0] master_out(input longint sum, input longint mst);
    longint v;
    v = gain(sum, mst);
    return v[23:0];                      // output depth
endfunction

// register copy using the bank's address map
function automatic void apply_write(input int a, input logic [7:0] d);
    if (a < 4) begin
        lvl_m[a] = d[6:0];
    end else if (a < 8) begin
        pan_m[a-4] = d[6:0];
    end else if (a < 12) begin
        mod_m[a-8] = $signed(d);
    end else if (a == 12) begin
        master_m = d[6:0];
    end                                  // anything above is unmapped
endfunction

function automatic void reset_model();
    for (int i = 0; i < 4; i++) begin
        lvl_m[i] = 0;
        pan_m[i] = 64;                   // centered
        mod_m[i] = 0;
    end
    master_m    = 0;
    master_prev = 0;
    acc_l       = 0;
    acc_r       = 0;
endfunction

`endif

// ==== dv/voice_mixer_tb.sv ====
`timescale 1ns/1ps

module voice_mixer_tb;

    import mix_pkg::*;

    logic                            sCLK_XVXENVS;
    logic                            rst_n;
    logic                            frame_sync;
    logic signed [ENV_W-1:0]         env_level;
    logic signed [SINE_W-1:0]        sine_sample;
    logic                            write;
    logic [ADR_W-1:0]                adr;
    logic [WDATA_W-1:0]              wdata;
    slot_t                           cur_slot;
    logic signed [MOD_W-1:0]         modulation;
    logic signed [AUD_BIT_DEPTH-1:0] lsound_out;
    logic signed [AUD_BIT_DEPTH-1:0] rsound_out;
    logic                            sound_valid;

    integer           seed = 32'h7963;
    int               errors;
    int               err_base;
    int               checks;
    int               cyc;
    int               exp_slot;
    bit               frame_seen;        // step saw sound_valid
    longint           acc_l;
    longint           acc_r;
    int               lvl_m [V_OSC];
    int               pan_m [V_OSC];
    int               mod_m [V_OSC];
    int               master_m;
    int               master_prev;       // master as the result stage sees it
    logic [MOD_W-1:0] mod_q [$];         // oldest first
    int               frm_cyc [$];
    longint           frm_l [$];
    longint           frm_r [$];

    `include "mix_model.svh"

    voice_mixer uut (.*);

    initial begin
        sCLK_XVXENVS = 1'b0;
        forever #4 sCLK_XVXENVS = ~sCLK_XVXENVS;
    end

    task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("** Error: %s = 0x%h, expected 0x%h, cycle %0d", name, got, exp, cyc);
        end
    endtask

    // check outputs at this falling edge, drive the next slot, wait one cycle
    task automatic step(input bit fs, input bit wr, input logic [ADR_W-1:0] a,
                        input logic [WDATA_W-1:0] d);
        longint amp;
        longint l;
        longint r;
        int     osc;
        bit     due;
        due        = frm_cyc.size() > 0 && frm_cyc[0] + 3 == cyc;
        frame_seen = sound_valid;
        check_hex("cur_slot", cur_slot, exp_slot);
        if (mod_q.size() == 2) begin
            check_hex("modulation", $unsigned(modulation), mod_q.pop_front());
        end
        check_hex("sound_valid", sound_valid, due);
        if (due) begin
            void'(frm_cyc.pop_front());
            l = frm_l.pop_front();
            r = frm_r.pop_front();
            if (sound_valid) begin
                check_hex("lsound_out", $unsigned(lsound_out), master_out(l, master_prev));
                check_hex("rsound_out", $unsigned(rsound_out), master_out(r, master_prev));
            end
        end
        master_prev = master_m;
        frame_sync  = fs;
        write       = wr;
        adr         = a;
        wdata       = d;
        env_level   = $random(seed);
        sine_sample = $random(seed);
        if (wr) begin
            apply_write(a, d);
        end
        osc = exp_slot % V_OSC;
        amp = amp_of(sine_sample, env_level);
        l   = gain(gain(amp, lvl_m[osc]), 127 - pan_m[osc]);
        r   = gain(gain(amp, lvl_m[osc]), pan_m[osc]);
        if (exp_slot == 0) begin         // previous frame is complete
            frm_cyc.push_back(cyc);
            frm_l.push_back(acc_l);
            frm_r.push_back(acc_r);
            acc_l = l;
            acc_r = r;
        end else begin
            acc_l += l;
            acc_r += r;
        end
        mod_q.push_back(slot_mod(amp, mod_m[osc]));
        exp_slot = fs ? 0 : (exp_slot + 1) % SLOTS;
        cyc++;
        @(negedge sCLK_XVXENVS);
    endtask

    task automatic run_cycles(input int n);
        repeat (n) step(0, 0, 0, 0);
    endtask

    task automatic wait_frame();
        int n = 0;
        do begin
            step(0, 0, 0, 0);
            n++;
        end while (!frame_seen && n < 40);
        if (!frame_seen) begin
            errors++;
            $display("timeout: no sound_valid within 40 cycles at cycle %0d", cyc);
        end
    endtask

    task automatic report_test(input int num, input string name);
        $display("test %0d %s: %0d errors", num, name, errors - err_base);
        err_base = errors;
    endtask

    initial begin
        rst_n       = 1'b0;
        frame_sync  = 1'b0;
        env_level   = '0;
        sine_sample = '0;
        write       = 1'b0;
        adr         = '0;
        wdata       = '0;
        errors      = 0;
        err_base    = 0;
        checks      = 0;
        cyc         = 0;
        exp_slot    = 0;
        reset_model();
        repeat (16) @(posedge sCLK_XVXENVS);
        @(negedge sCLK_XVXENVS);
        rst_n = 1'b1;
        check_hex("lsound_out", $unsigned(lsound_out), 0);     // reset values
        check_hex("rsound_out", $unsigned(rsound_out), 0);
        check_hex("modulation", $unsigned(modulation), 0);

        repeat (3) wait_frame();         // silent frames across the slot wrap
        report_test(1, "reset and idle");

        for (int i = 0; i < V_OSC; i++) begin
            step(0, 1, ADR_MOD_BASE + i, $random(seed));
        end
        run_cycles(64);
        report_test(2, "modulation");

        for (int i = 0; i < V_OSC; i++) begin
            step(0, 1, ADR_LVL_BASE + i, 8'd127);
            step(0, 1, ADR_PAN_BASE + i, 8'd0);      // hard left
        end
        step(0, 1, ADR_MASTER, 8'd127);
        repeat (2) wait_frame();
        repeat (2) begin
            wait_frame();
            check_hex("rsound_out", $unsigned(rsound_out), 0);
        end
        for (int i = 0; i < V_OSC; i++) begin
            step(0, 1, ADR_PAN_BASE + i, 8'd127);
        end
        repeat (2) wait_frame();
        repeat (2) begin
            wait_frame();
            check_hex("lsound_out", $unsigned(lsound_out), 0);
        end
        report_test(3, "pan extremes");

        for (int i = 0; i < V_OSC; i++) begin
            step(0, 1, ADR_LVL_BASE + i, $random(seed));
            step(0, 1, ADR_PAN_BASE + i, $random(seed));
        end
        step(0, 1, ADR_MASTER, $random(seed));
        step(1, 0, 0, 0);
        repeat (20) wait_frame();
        report_test(4, "random frames");

        wait_frame();
        run_cycles(6);
        step(1, 0, 0, 0);                // restart mid-frame
        check_hex("cur_slot", cur_slot, 0);
        repeat (2) wait_frame();         // partial frame, then a full one
        report_test(5, "mid-frame sync");

        for (int i = 0; i < 6; i++) begin
            step(0, 1, 7'd13 + ($unsigned($random(seed)) % 115), $random(seed));
        end
        repeat (3) wait_frame();
        report_test(6, "unmapped writes");

        $display("tests 6, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog/voice_mixer.sv ====
`timescale 1ns/1ps

module voice_mixer (
    input  logic                                        sCLK_XVXENVS,
    input  logic                                        rst_n,
    input  logic                                        frame_sync,
    input  logic signed [mix_pkg::ENV_W-1:0]            env_level,
    input  logic signed [mix_pkg::SINE_W-1:0]           sine_sample,
    input  logic                                        write,
    input  logic [mix_pkg::ADR_W-1:0]                   adr,
    input  logic [mix_pkg::WDATA_W-1:0]                 wdata,
    output mix_pkg::slot_t                              cur_slot,
    output logic signed [mix_pkg::MOD_W-1:0]            modulation,
    output logic signed [mix_pkg::AUD_BIT_DEPTH-1:0]    lsound_out,
    output logic signed [mix_pkg::AUD_BIT_DEPTH-1:0]    rsound_out,
    output logic                                        sound_valid
);

    import mix_pkg::*;

    osc_param_t         osc_param [V_OSC];
    logic [GAIN_W-1:0]  master_vol;
    dec_item_t          dec_item;       // stage 1 -> 2
    exec_item_t         exec_item;      // stage 2 -> 3

    mix_param_regs u_regs (
        .sCLK_XVXENVS (sCLK_XVXENVS),
        .rst_n        (rst_n),
        .write        (write),
        .adr          (adr),
        .wdata        (wdata),
        .osc_param    (osc_param),
        .master_vol   (master_vol)
    );

    mix_slot_decode u_decode (
        .sCLK_XVXENVS (sCLK_XVXENVS),
        .rst_n        (rst_n),
        .frame_sync   (frame_sync),
        .env_level    (env_level),
        .sine_sample  (sine_sample),
        .cur_slot     (cur_slot),
        .dec_item     (dec_item)
    );

    mix_voice_execute u_execute (
        .sCLK_XVXENVS (sCLK_XVXENVS),
        .rst_n        (rst_n),
        .dec_item     (dec_item),
        .osc_param    (osc_param),
        .exec_item    (exec_item),
        .modulation   (modulation)
    );

    mix_stereo_result u_result (
        .sCLK_XVXENVS (sCLK_XVXENVS),
        .rst_n        (rst_n),
        .exec_item    (exec_item),
        .master_vol   (master_vol),
        .lsound_out   (lsound_out),
        .rsound_out   (rsound_out),
        .sound_valid  (sound_valid)
    );

endmodule

// ==== verilog/mix_stereo_result.sv ====
`timescale 1ns/1ps

module mix_stereo_result (
    input  logic                                        sCLK_XVXENVS,
    input  logic                                        rst_n,
    input  mix_pkg::exec_item_t                         exec_item,
    input  logic [mix_pkg::GAIN_W-1:0]                  master_vol,
    output logic signed [mix_pkg::AUD_BIT_DEPTH-1:0]    lsound_out,
    output logic signed [mix_pkg::AUD_BIT_DEPTH-1:0]    rsound_out,
    output logic                                        sound_valid
);

    import mix_pkg::*;

    logic signed [AUD_BIT_DEPTH-1:0]        acc_l;     // frame sums
    logic signed [AUD_BIT_DEPTH-1:0]        acc_r;
    logic signed [AUD_BIT_DEPTH+GAIN_W:0]   mst_l;
    logic signed [AUD_BIT_DEPTH+GAIN_W:0]   mst_r;
    logic signed [AUD_BIT_DEPTH-1:0]        vol_l;
    logic signed [AUD_BIT_DEPTH-1:0]        vol_r;

    // master volume on the finished frame
    always_comb begin
        mst_l = acc_l * $signed({1'b0, master_vol});
        mst_r = acc_r * $signed({1'b0, master_vol});
        vol_l = mst_l[AUD_BIT_DEPTH+GAIN_SHIFT-1:GAIN_SHIFT];    // >>> 7 then truncate
        vol_r = mst_r[AUD_BIT_DEPTH+GAIN_SHIFT-1:GAIN_SHIFT];
    end

    always_ff @(posedge sCLK_XVXENVS) begin
        if (!rst_n) begin
            acc_l       <= '0;
            acc_r       <= '0;
            lsound_out  <= '0;
            rsound_out  <= '0;
            sound_valid <= 1'b0;
        end else begin
            sound_valid <= 1'b0;
            if (exec_item.vld) begin
                if (exec_item.first) begin
                    lsound_out  <= vol_l;      // previous frame out
                    rsound_out  <= vol_r;
                    sound_valid <= 1'b1;
                    acc_l       <= exec_item.left;     // new frame starts here
                    acc_r       <= exec_item.right;
                end else begin
                    acc_l <= acc_l + exec_item.left;
                    acc_r <= acc_r + exec_item.right;
                end
            end
        end
    end

endmodule

// ==== verilog/mix_voice_execute.sv ====
`timescale 1ns/1ps

module mix_voice_execute (
    input  logic                                sCLK_XVXENVS,
    input  logic                                rst_n,
    input  mix_pkg::dec_item_t                  dec_item,
    input  mix_pkg::osc_param_t                 osc_param [mix_pkg::V_OSC],
    output mix_pkg::exec_item_t                 exec_item,
    output logic signed [mix_pkg::MOD_W-1:0]    modulation
);

    import mix_pkg::*;

    osc_param_t                            prm;
    logic [GAIN_W-1:0]                     pan_inv;
    logic signed [SINE_W+ENV_W-1:0]        amp_full;
    logic signed [AMP_W-1:0]               amp;
    logic signed [AMP_W+GAIN_W:0]          scl_full;
    logic signed [SCL_W-1:0]               scaled;
    logic signed [SCL_W+GAIN_W:0]          lft_full;
    logic signed [SCL_W+GAIN_W:0]          rgt_full;
    logic signed [PAN_W-1:0]               lft;
    logic signed [PAN_W-1:0]               rgt;
    logic signed [AMP_W+MODAMT_W-1:0]      mod_full;
    logic                                  vld_q;
    logic                                  first_q;
    logic signed [AUD_BIT_DEPTH-1:0]       left_q;
    logic signed [AUD_BIT_DEPTH-1:0]       right_q;

    always_comb begin
        prm      = osc_param[dec_item.slot.osc];       // params shared by all voices
        pan_inv  = GAIN_MAX - prm.pan;
        amp_full = dec_item.sine * dec_item.env;
        amp      = amp_full[SINE_W+ENV_W-1:GAIN_SHIFT];    // >>> 7
        scl_full = amp * $signed({1'b0, prm.lvl});
        scaled   = scl_full[AMP_W+GAIN_W:GAIN_SHIFT];
        lft_full = scaled * $signed({1'b0, pan_inv});
        rgt_full = scaled * $signed({1'b0, prm.pan});
        lft      = lft_full[SCL_W+GAIN_W:GAIN_SHIFT];
        rgt      = rgt_full[SCL_W+GAIN_W:GAIN_SHIFT];
        mod_full = amp * prm.mod_amt;
    end

    always_ff @(posedge sCLK_XVXENVS) begin
        if (!rst_n) begin
            vld_q      <= 1'b0;
            first_q    <= 1'b0;
            modulation <= '0;
        end else begin
            vld_q      <= dec_item.vld;
            first_q    <= dec_item.first;
            modulation <= mod_full[MOD_SHIFT+MOD_W-1:MOD_SHIFT];   // >>> 14 into 11 bits
        end
    end

    // sign extend the panned sample to the output depth
    always_ff @(posedge sCLK_XVXENVS) begin
        left_q  <= {{(AUD_BIT_DEPTH - PAN_W){lft[PAN_W-1]}}, lft};
        right_q <= {{(AUD_BIT_DEPTH - PAN_W){rgt[PAN_W-1]}}, rgt};
    end

    assign exec_item = '{vld: vld_q, first: first_q, left: left_q, right: right_q};

endmodule

// ==== verilog/mix_slot_decode.sv ====
`timescale 1ns/1ps

module mix_slot_decode (
    input  logic                                sCLK_XVXENVS,
    input  logic                                rst_n,
    input  logic                                frame_sync,
    input  logic signed [mix_pkg::ENV_W-1:0]    env_level,
    input  logic signed [mix_pkg::SINE_W-1:0]   sine_sample,
    output mix_pkg::slot_t                      cur_slot,
    output mix_pkg::dec_item_t                  dec_item
);

    import mix_pkg::*;

    logic [SLOT_W-1:0]        slot_cnt;
    logic                     first;
    logic                     vld_q;
    logic                     first_q;
    slot_t                    slot_q;
    logic signed [SINE_W-1:0] sine_q;
    logic signed [ENV_W-1:0]  env_q;

    // voice in the upper bits, osc in the lower
    assign cur_slot = slot_t'(slot_cnt);
    assign first    = (slot_cnt == '0);

    always_ff @(posedge sCLK_XVXENVS) begin
        if (!rst_n) begin
            slot_cnt <= '0;
        end else if (frame_sync || slot_cnt == SLOT_W'(SLOTS - 1)) begin
            slot_cnt <= '0;                            // restart or wrap
        end else begin
            slot_cnt <= slot_cnt + 1'b1;
        end
    end

    always_ff @(posedge sCLK_XVXENVS) begin
        if (!rst_n) begin
            vld_q   <= 1'b0;
            first_q <= 1'b0;
        end else begin
            vld_q   <= 1'b1;                           // one item every cycle
            first_q <= first;
        end
    end

    // external generators answer for cur_slot in the same cycle
    always_ff @(posedge sCLK_XVXENVS) begin
        slot_q <= cur_slot;
        sine_q <= sine_sample;
        env_q  <= env_level;
    end

    assign dec_item = '{vld: vld_q, first: first_q, slot: slot_q, sine: sine_q, env: env_q};

endmodule

// ==== verilog/mix_param_regs.sv ====
`timescale 1ns/1ps

module mix_param_regs (
    input  logic                            sCLK_XVXENVS,
    input  logic                            rst_n,
    input  logic                            write,
    input  logic [mix_pkg::ADR_W-1:0]       adr,
    input  logic [mix_pkg::WDATA_W-1:0]     wdata,
    output mix_pkg::osc_param_t             osc_param [mix_pkg::V_OSC],
    output logic [mix_pkg::GAIN_W-1:0]      master_vol
);

    import mix_pkg::*;

    reg_sel_e           sel;        // field addressed by adr
    logic [O_WIDTH-1:0] osc_idx;

    // 4 lvl, 4 pan and 4 mod_amt addresses, then master
    always_comb begin
        osc_idx = adr[O_WIDTH-1:0];                    // bases are multiples of V_OSC
        if (adr < ADR_PAN_BASE) begin
            sel = SEL_LVL;
        end else if (adr < ADR_MOD_BASE) begin
            sel = SEL_PAN;
        end else if (adr < ADR_MASTER) begin
            sel = SEL_MOD;
        end else if (adr == ADR_MASTER) begin
            sel = SEL_MASTER;
        end else begin
            sel = SEL_NONE;                            // unmapped address
        end
    end

    always_ff @(posedge sCLK_XVXENVS) begin
        if (!rst_n) begin
            for (int i = 0; i < V_OSC; i++) begin
                osc_param[i].lvl     <= '0;            // silent until configured
                osc_param[i].pan     <= PAN_CENTER;
                osc_param[i].mod_amt <= '0;
            end
            master_vol <= '0;
        end else if (write) begin
            case (sel)
                SEL_LVL: begin
                    osc_param[osc_idx].lvl <= wdata[GAIN_W-1:0];
                end
                SEL_PAN: begin
                    osc_param[osc_idx].pan <= wdata[GAIN_W-1:0];
                end
                SEL_MOD: begin
                    osc_param[osc_idx].mod_amt <= wdata;   // signed amount
                end
                SEL_MASTER: begin
                    master_vol <= wdata[GAIN_W-1:0];
                end
                default: begin
                end
            endcase
        end
    end

endmodule

// ==== verilog/mix_pkg.sv ====
package mix_pkg;

    localparam int VOICES        = 4;
    localparam int V_OSC         = 4;                    // oscs per voice
    localparam int SLOTS         = VOICES * V_OSC;       // slots per audio frame
    localparam int V_WIDTH       = $clog2(VOICES);
    localparam int O_WIDTH       = $clog2(V_OSC);
    localparam int SLOT_W        = V_WIDTH + O_WIDTH;
    localparam int AUD_BIT_DEPTH = 24;
    localparam int SINE_W        = 17;
    localparam int ENV_W         = 8;
    localparam int MOD_W         = 11;
    localparam int MODAMT_W      = 8;
    localparam int GAIN_W        = 7;                    // lvl, pan and master width
    localparam int GAIN_SHIFT    = 7;
    localparam int MOD_SHIFT     = 14;
    localparam int ADR_W         = 7;
    localparam int WDATA_W       = 8;

    // widths after each gain stage with its shift applied
    localparam int AMP_W = SINE_W + ENV_W - GAIN_SHIFT;  // sine * env
    localparam int SCL_W = AMP_W + GAIN_W + 1 - GAIN_SHIFT;  // * lvl
    localparam int PAN_W = SCL_W + GAIN_W + 1 - GAIN_SHIFT;  // * pan

    localparam logic [GAIN_W-1:0] GAIN_MAX   = {GAIN_W{1'b1}};  // 127
    localparam logic [GAIN_W-1:0] PAN_CENTER = 7'd64;

    localparam logic [ADR_W-1:0] ADR_LVL_BASE = 7'd0;
    localparam logic [ADR_W-1:0] ADR_PAN_BASE = 7'd4;
    localparam logic [ADR_W-1:0] ADR_MOD_BASE = 7'd8;
    localparam logic [ADR_W-1:0] ADR_MASTER   = 7'd12;

    typedef enum logic [2:0] {
        SEL_LVL,
        SEL_PAN,
        SEL_MOD,
        SEL_MASTER,
        SEL_NONE
    } reg_sel_e;

    typedef struct packed {
        logic [V_WIDTH-1:0] voice;
        logic [O_WIDTH-1:0] osc;
    } slot_t;

    typedef struct packed {
        logic [GAIN_W-1:0]          lvl;
        logic [GAIN_W-1:0]          pan;      // 0 = hard left
        logic signed [MODAMT_W-1:0] mod_amt;
    } osc_param_t;

    typedef struct packed {
        logic                     vld;
        logic                     first;    // slot 0 of a frame
        slot_t                    slot;
        logic signed [SINE_W-1:0] sine;
        logic signed [ENV_W-1:0]  env;
    } dec_item_t;

    typedef struct packed {
        logic                            vld;
        logic                            first;
        logic signed [AUD_BIT_DEPTH-1:0] left;
        logic signed [AUD_BIT_DEPTH-1:0] right;
    } exec_item_t;

endpackage
